// File: src/pi_cfg.svh
// fs-based blender timing; get_time and delay need a real named tu (seconds per time unit) in scope
`ifndef PI_CFG_SVH
`define PI_CFG_SVH

// phase grid
`define PI_NPH    4          // input phases, power of two
`define PI_NFINE  3          // fine stages, 2**3 steps per coarse step

// blender cell timing in fs
`define PI_TD_FS  1000000    // 1 ns per blender cell
`define PI_RJ_FS  0          // peak random jitter, off by default

// register map
`define PI_ADDR_W 2          // code and ctrl at 0 and 1, rest unmapped

// time helpers for the behavioral cells
`define get_time  ($realtime * tu)
`define delay(t)  #((t) / tu)

`endif

// File: src/pi_pkg.sv
// types for the register word and the blender model class; the class is simulation only
`include "pi_cfg.svh"

package pi_pkg;

    localparam int pi_coarse_w = $clog2(`PI_NPH);          // coarse code bits
    localparam int pi_fine_w   = `PI_NFINE;                // fine code bits
    localparam int pi_word_w   = pi_coarse_w + pi_fine_w;  // wishbone data width

    // code register view, coarse in the msbs
    typedef struct packed {
        logic [pi_coarse_w-1:0] coarse;  // picks phase pair
        logic [pi_fine_w-1:0]   fine;    // position inside pair
    } phase_code_t;

    // control register view
    typedef struct packed {
        logic [pi_word_w-2:0] rsvd;  // reads zero
        logic                 enable;
    } pi_ctrl_t;

    // one bus word, meaning depends on address
    typedef union packed {
        phase_code_t code;
        pi_ctrl_t    ctrl;
    } pi_reg_word_t;

    typedef enum logic [`PI_ADDR_W-1:0] {
        PI_ADDR_CODE = 0,
        PI_ADDR_CTRL = 1
    } pi_addr_e;

    // blender cell parameters, all in seconds
    class pi_param;
        real td_mixer1b;  // cell delay
        real rj_pk;       // peak jitter

        function new();
            td_mixer1b = `PI_TD_FS * 1.0e-15;
            rj_pk      = `PI_RJ_FS * 1.0e-15;
        endfunction

        // uniform jitter in +-rj_pk
        function real get_rj_mixer1b();
            if (rj_pk == 0.0) return 0.0;
            return rj_pk * (($urandom_range(2000) / 1000.0) - 1.0);
        endfunction
    endclass

endpackage

// File: src/pi_ctrl_if.sv
// settings from the register block to the datapath; code only valid for capture on update
`timescale 1ns/1ns

interface pi_ctrl_if (
    input logic clk  // register clock, datapath captures on it
);
    import pi_pkg::*;

    phase_code_t code;    // coarse and fine code
    logic        enable;  // output gate
    logic        update;  // one clk pulse, capture point for code

    // register side
    modport ctrl (
        output code,
        output enable,
        output update
    );

    // datapath side
    modport dp (
        input clk,
        input code,
        input enable,
        input update
    );

endinterface

// File: src/pi_wb_ctrl.sv
// wishbone classic slave, single cycle registered ack; update only when a write changes a value
`timescale 1ns/1ns
`include "pi_cfg.svh"

module pi_wb_ctrl (
    input  logic                   clk,
    input  logic                   rst_n,
    input  logic                   wb_cyc,
    input  logic                   wb_stb,
    input  logic                   wb_we,
    input  logic [`PI_ADDR_W-1:0]  wb_adr,
    input  pi_pkg::pi_reg_word_t   wb_dat_w,
    output pi_pkg::pi_reg_word_t   wb_dat_r,
    output logic                   wb_ack,
    pi_ctrl_if.ctrl                ctl
);
    import pi_pkg::*;

    phase_code_t  code_q;    // phase code register
    logic         en_q;      // enable bit
    logic         upd_pend;  // write changed something, set with ack
    logic         upd_q;     // update strobe, cycle after ack
    logic         acc;       // new access this cycle
    logic         wr_chg;    // write data differs from register
    pi_addr_e     adr_e;
    pi_reg_word_t rd_word;

    assign adr_e = pi_addr_e'(wb_adr);  // out of range values stay unmapped

    // one access per stb, ack blocks a second one
    assign acc = wb_cyc & wb_stb & ~wb_ack;

    // compare only the implemented bits
    always_comb begin
        wr_chg = 1'b0;
        case (adr_e)
            PI_ADDR_CODE: wr_chg = (wb_dat_w.code != code_q);
            PI_ADDR_CTRL: wr_chg = (wb_dat_w.ctrl.enable != en_q);
            default:      wr_chg = 1'b0;  // unmapped write ignored
        endcase
    end

    // readback mux
    always_comb begin
        rd_word = '0;
        case (adr_e)
            PI_ADDR_CODE: rd_word.code = code_q;
            PI_ADDR_CTRL: rd_word.ctrl.enable = en_q;  // rsvd stays 0
            default:      rd_word = '0;
        endcase
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            wb_ack   <= 1'b0;
            code_q   <= '0;
            en_q     <= 1'b0;
            upd_pend <= 1'b0;
            upd_q    <= 1'b0;
        end else begin
            wb_ack   <= acc;                    // one clk after stb seen
            upd_pend <= acc & wb_we & wr_chg;
            upd_q    <= upd_pend;               // lands after the ack cycle
            if (acc && wb_we) begin
                case (adr_e)
                    PI_ADDR_CODE: code_q <= wb_dat_w.code;
                    PI_ADDR_CTRL: en_q   <= wb_dat_w.ctrl.enable;
                    default: ;
                endcase
            end
        end
    end

    // read data, valid together with ack
    always_ff @(posedge clk) begin
        if (acc) begin
            wb_dat_r <= rd_word;
        end
    end

    assign ctl.code   = code_q;
    assign ctl.enable = en_q;
    assign ctl.update = upd_q;

endmodule

// File: src/phase_select_mux.sv
// coarse pair select, changes only at update; switching mid-period may cut a pulse
`timescale 1ns/1ns
`include "pi_cfg.svh"

module phase_select_mux (
    input  logic              rst_n,
    input  logic [`PI_NPH-1:0] ph_in,     // phase k rises k*period/NPH later
    pi_ctrl_if.dp             ctl,
    output logic              ph_early,
    output logic              ph_late
);
    import pi_pkg::*;

    logic [pi_coarse_w-1:0] sel_q;    // early phase index
    logic [pi_coarse_w-1:0] sel_nxt;  // late phase index

    // capture coarse code on the update strobe only
    always_ff @(posedge ctl.clk or negedge rst_n) begin
        if (!rst_n) begin
            sel_q <= '0;
        end else if (ctl.update) begin
            sel_q <= ctl.code.coarse;
        end
    end

    // neighbour phase, last one wraps to phase 0
    assign sel_nxt = (sel_q == `PI_NPH - 1) ? '0 : sel_q + 1'b1;

    // same path for both, no added skew
    assign ph_early = ph_in[sel_q];
    assign ph_late  = ph_in[sel_nxt];

endmodule

// File: src/phase_blender_1bit.sv
// behavioral timing model only, not for synthesis; mid-point uses the spread of the previous edge pair
`timescale 1ns/1ns
`include "pi_cfg.svh"

module phase_blender_1bit (
    input  logic ph_in1,    // clocks being blended
    input  logic ph_in0,
    input  logic en_mixer,  // 1 mid-point, 0 leading edge
    output logic ph_out     // blended phase
);
    timeunit 1fs;
    timeprecision 1fs;
    import pi_pkg::*;

    localparam real tu = 1.0 / 1s;  // seconds per time unit

    pi_param pi_obj = new();        // cell delay and jitter source

    real  wgt;             // blend weight
    real  rj;              // jitter for this edge
    real  t_lead = 0.0;    // arrival of the first edge [s]
    real  tdiff  = 0.0;    // spread of the last pair [s]
    logic pending = 1'b0;  // first edge seen, second outstanding
    logic lvl;             // level the leading edge brings
    logic ph_in0_q;        // ph_in0 before this event

    assign wgt = en_mixer ? 0.5 : 0.0;

    always @(ph_in0 or ph_in1) begin
        rj = pi_obj.get_rj_mixer1b();
        if (ph_in0 !== ph_in1) begin
            // leading edge from whichever input just moved
            t_lead  = `get_time;
            pending = 1'b1;
            lvl     = (ph_in0 !== ph_in0_q) ? ph_in0 : ph_in1;
            ph_out <= `delay(pi_obj.td_mixer1b + wgt * tdiff + rj) lvl;
        end else if (pending) begin
            // trailing edge closes the pair
            tdiff   = `get_time - t_lead;
            pending = 1'b0;
        end else begin
            // both moved together so only the cell delay
            ph_out <= `delay(pi_obj.td_mixer1b + rj) ph_in0;
        end
        ph_in0_q = ph_in0;
    end

endmodule

// File: src/phase_blender_tree.sv
// binary fine interpolation, msb first; every stage adds one cell delay to both kept edges
`timescale 1ns/1ns
`include "pi_cfg.svh"

module phase_blender_tree (
    input  logic  rst_n,
    input  logic  ph_early,  // earlier of the coarse pair
    input  logic  ph_late,
    pi_ctrl_if.dp ctl,
    output logic  ph_out
);

    logic [`PI_NFINE-1:0] fine_q;  // fine code, held between updates
    logic [`PI_NFINE:0]   pe;      // early edge into each stage, last one is the result
    logic [`PI_NFINE-1:0] pl;      // late edge into each stage
    logic [`PI_NFINE-1:0] mid;     // mid-point of each pair
    logic [`PI_NFINE-1:0] kept;    // delayed copy of the edge that survives
    logic [`PI_NFINE-1:0] kept_src;

    always_ff @(posedge ctl.clk or negedge rst_n) begin
        if (!rst_n) begin
            fine_q <= '0;
        end else if (ctl.update) begin
            fine_q <= ctl.code.fine;
        end
    end

    assign pe[0] = ph_early;
    assign pl[0] = ph_late;

    for (genvar s = 0; s < `PI_NFINE; s++) begin : g_stage
        localparam int bit_idx = `PI_NFINE - 1 - s;  // stage 0 takes the msb

        // 1 keeps the late edge, 0 the early one
        assign kept_src[s] = fine_q[bit_idx] ? pl[s] : pe[s];

        phase_blender_1bit u_mid (  // half way between the pair
            .ph_in1   (pl[s]),
            .ph_in0   (pe[s]),
            .en_mixer (1'b1),
            .ph_out   (mid[s])
        );

        phase_blender_1bit u_pass (  // same delay as u_mid, no blend
            .ph_in1   (kept_src[s]),
            .ph_in0   (kept_src[s]),
            .en_mixer (1'b0),
            .ph_out   (kept[s])
        );

        // new pair (mid, late) or (early, mid)
        assign pe[s+1] = fine_q[bit_idx] ? mid[s] : kept[s];
        if (s < `PI_NFINE - 1) begin : g_late
            assign pl[s+1] = fine_q[bit_idx] ? kept[s] : mid[s];
        end
    end

    assign ph_out = pe[`PI_NFINE] & ctl.enable;  // low while disabled

endmodule

// File: src/phase_interp_top.sv
// phase interpolator top; ph_in must be NPH evenly spaced phases and code changes apply after update
`timescale 1ns/1ns
`include "pi_cfg.svh"

module phase_interp_top (
    input  logic                         clk,       // register clock
    input  logic                         rst_n,
    input  logic                         wb_cyc,
    input  logic                         wb_stb,
    input  logic                         wb_we,
    input  logic [`PI_ADDR_W-1:0]        wb_adr,
    input  logic [pi_pkg::pi_word_w-1:0] wb_dat_w,
    output logic [pi_pkg::pi_word_w-1:0] wb_dat_r,
    output logic                         wb_ack,
    input  logic [`PI_NPH-1:0]           ph_in,     // multiphase clock in
    output logic                         ph_out     // interpolated clock
);

    logic ph_early;  // selected pair
    logic ph_late;

    pi_ctrl_if u_ctl_if (.clk(clk));

    pi_wb_ctrl u_wb_ctrl (
        .clk      (clk),
        .rst_n    (rst_n),
        .wb_cyc   (wb_cyc),
        .wb_stb   (wb_stb),
        .wb_we    (wb_we),
        .wb_adr   (wb_adr),
        .wb_dat_w (wb_dat_w),
        .wb_dat_r (wb_dat_r),
        .wb_ack   (wb_ack),
        .ctl      (u_ctl_if.ctrl)
    );

    phase_select_mux u_phase_select_mux (
        .rst_n    (rst_n),
        .ph_in    (ph_in),
        .ctl      (u_ctl_if.dp),
        .ph_early (ph_early),
        .ph_late  (ph_late)
    );

    phase_blender_tree u_phase_blender_tree (
        .rst_n    (rst_n),
        .ph_early (ph_early),
        .ph_late  (ph_late),
        .ctl      (u_ctl_if.dp),
        .ph_out   (ph_out)
    );

endmodule

// File: sim/tb_clk_gen.sv
// ideal 50% duty model phases on a 2*NPH step grid; clk edges sit half a step off the phase edges
`timescale 1ns/1ns
`include "pi_cfg.svh"

module tb_clk_gen #(
    parameter int clk_period_ns = 40,
    parameter int ph_period_ns  = 320,
    parameter int rst_cycles    = 4
) (
    output logic               clk,
    output logic               rst_n,
    output logic [`PI_NPH-1:0] ph     // phase k rises k*period/NPH after phase 0
);
    localparam int n_steps = 2 * `PI_NPH;              // grid points per phase period
    localparam int step_ns = ph_period_ns / n_steps;  // 40 ns

    int step;  // position inside the phase period
    int pos;   // step seen from phase k

    initial begin
        clk = 1'b0;
        forever #(clk_period_ns / 2) clk = ~clk;  // first rise at 20 ns
    end

    // reset released on a rising edge after rst_cycles clocks
    initial begin
        rst_n = 1'b0;
        repeat (rst_cycles) @(posedge clk);
        rst_n <= 1'b1;
    end

    initial begin
        step = 0;
        forever begin
            for (int k = 0; k < `PI_NPH; k++) begin
                pos   = (step + n_steps - 2 * k) % n_steps;  // two steps between phases
                ph[k] = (pos < `PI_NPH);                     // high for half a period
            end
            #(step_ns);
            step = (step + 1) % n_steps;
        end
    end

endmodule

// File: sim/phase_interp_assert.sv
// handshake checks on the register block, bound into pi_wb_ctrl; inactive while rst_n is low
`timescale 1ns/1ns

module phase_interp_assert (
    input logic clk,
    input logic rst_n,
    input logic wb_cyc,
    input logic wb_stb,
    input logic wb_we,
    input logic wb_ack,
    input logic update   // internal update strobe
);
    int fail_cnt = 0;  // assertion failures so far

    // ack answers an open cycle only
    ack_in_cycle: assert property (@(posedge clk) disable iff (!rst_n)
        wb_ack |-> (wb_cyc && wb_stb))
        else begin
            $error("ack seen without cyc and stb");
            fail_cnt++;
        end

    // single cycle ack
    ack_one_cycle: assert property (@(posedge clk) disable iff (!rst_n)
        wb_ack |=> !wb_ack)
        else begin
            $error("ack held longer than one cycle");
            fail_cnt++;
        end

    // strobe only in the cycle after a write ack
    update_after_write: assert property (@(posedge clk) disable iff (!rst_n)
        update |-> $past(wb_ack && wb_we))
        else begin
            $error("update without a preceding write ack");
            fail_cnt++;
        end

endmodule

bind pi_wb_ctrl phase_interp_assert u_wb_assert (
    .clk    (clk),
    .rst_n  (rst_n),
    .wb_cyc (wb_cyc),
    .wb_stb (wb_stb),
    .wb_we  (wb_we),
    .wb_ack (wb_ack),
    .update (upd_q)
);

// File: sim/phase_interp_tb.sv
// offsets in whole ns only, so the cell delay must be a multiple of 1 ns; stops at first mismatch
`timescale 1ns/1ns
`include "pi_cfg.svh"

module phase_interp_tb;
    import pi_pkg::*;

    localparam int ph_period_ns = 320;                           // model phase period
    localparam int coarse_ns    = ph_period_ns / `PI_NPH;        // 80 between phases
    localparam int fine_ns      = coarse_ns / (1 << `PI_NFINE);  // 10 per fine step
    localparam int tree_ns      = `PI_NFINE * `PI_TD_FS / 1000000;
    localparam int n_codes      = 4 + 32 + 30 + 1;               // coarse, sweep, random, re-enable
    localparam int watchdog_ns  = (n_codes + 8) * 3 * ph_period_ns;

    logic                  clk;
    logic                  rst_n;
    logic [`PI_NPH-1:0]    ph_in;
    logic                  wb_cyc;
    logic                  wb_stb;
    logic                  wb_we;
    logic [`PI_ADDR_W-1:0] wb_adr;
    logic [pi_word_w-1:0]  wb_dat_w;
    logic [pi_word_w-1:0]  wb_dat_r;
    logic                  wb_ack;
    logic                  ph_out;

    real                  t_ph0 = 0.0;  // last rise of ph_in[0]
    int                   rise_cnt = 0; // ph_out rising edges
    integer               seed;
    string                chk_name;     // handed to the checker
    int                   chk_exp;
    event                 start_chk;
    event                 chk_done;
    logic [pi_word_w-1:0] rd_val;
    logic [pi_word_w-1:0] code;         // last code written
    integer               rnd;
    int                   edges0;

    tb_clk_gen u_clk_gen (.clk(clk), .rst_n(rst_n), .ph(ph_in));

    phase_interp_top u_phase_interp_top (
        .clk      (clk),
        .rst_n    (rst_n),
        .wb_cyc   (wb_cyc),
        .wb_stb   (wb_stb),
        .wb_we    (wb_we),
        .wb_adr   (wb_adr),
        .wb_dat_w (wb_dat_w),
        .wb_dat_r (wb_dat_r),
        .wb_ack   (wb_ack),
        .ph_in    (ph_in),
        .ph_out   (ph_out)
    );

    // offset of the ph_out rise after the ph_in[0] rise
    function automatic int expected_offset(input logic [pi_word_w-1:0] c);
        int coarse;
        int fine;
        coarse = int'(c >> `PI_NFINE);
        fine   = int'(c) & ((1 << `PI_NFINE) - 1);
        return (coarse * coarse_ns + fine * fine_ns + tree_ns) % ph_period_ns;
    endfunction

    task automatic check_eq(input string name, input logic [31:0] expected,
                            input logic [31:0] actual);
        if (actual !== expected) begin
            $display("[ERROR] %s: expected %0d, actual %0d", name, expected, actual);
            $display("Simulation finished: FAIL");
            $fatal(1, "mismatch in %s", name);
        end
    endtask

    task automatic bus_write(input logic [`PI_ADDR_W-1:0] adr, input logic [pi_word_w-1:0] dat);
        @(posedge clk);
        wb_cyc   <= 1'b1;
        wb_stb   <= 1'b1;
        wb_we    <= 1'b1;
        wb_adr   <= adr;
        wb_dat_w <= dat;
        @(posedge clk);
        while (!wb_ack) @(posedge clk);  // ack as it was before this edge
        wb_cyc <= 1'b0;
        wb_stb <= 1'b0;
        wb_we  <= 1'b0;
    endtask

    task automatic bus_read(input logic [`PI_ADDR_W-1:0] adr, output logic [pi_word_w-1:0] dat);
        @(posedge clk);
        wb_cyc <= 1'b1;
        wb_stb <= 1'b1;
        wb_we  <= 1'b0;
        wb_adr <= adr;
        @(posedge clk);
        while (!wb_ack) @(posedge clk);
        dat = wb_dat_r;  // valid with ack
        wb_cyc <= 1'b0;
        wb_stb <= 1'b0;
    endtask

    task automatic measure_offset(input string name, input logic [pi_word_w-1:0] c);
        @(posedge clk);  // update pulse is captured on this edge
        chk_name = name;
        chk_exp  = expected_offset(c);
        -> start_chk;
        @(chk_done);
    endtask

    task automatic apply_code(input string name, input logic [pi_word_w-1:0] c);
        bus_write(PI_ADDR_CODE, c);
        measure_offset(name, c);
    endtask

    always @(posedge ph_in[0]) t_ph0 = $realtime;
    always @(posedge ph_out) rise_cnt++;

    // compares one settled output edge per request
    always begin
        @(start_chk);
        #(2 * ph_period_ns);  // stale pair state flushed out
        @(posedge ph_out);
        check_eq(chk_name, chk_exp, $rtoi($realtime - t_ph0 + 0.5));
        -> chk_done;
    end

    // any bound handshake assertion ends the run at once
    always @(u_phase_interp_top.u_wb_ctrl.u_wb_assert.fail_cnt) begin
        if (u_phase_interp_top.u_wb_ctrl.u_wb_assert.fail_cnt != 0) begin
            $display("bus handshake assertion failed");
            $display("Simulation finished: FAIL");
            $fatal(1, "assertion failure");
        end
    end

    initial begin
        #(watchdog_ns);
        $display("timeout: test did not finish");
        $display("Simulation finished: FAIL");
        $fatal(1, "watchdog expired");
    end

    initial begin
        seed     = 32'h4908_fc6e;
        wb_cyc   = 1'b0;
        wb_stb   = 1'b0;
        wb_we    = 1'b0;
        wb_adr   = '0;
        wb_dat_w = '0;
        @(posedge rst_n);
        edges0 = rise_cnt;  // disabled output stays quiet
        #(2 * ph_period_ns);
        check_eq("idle_edges", 0, rise_cnt - edges0);
        check_eq("idle_level", 0, ph_out);
        bus_read(PI_ADDR_CODE, rd_val);
        check_eq("reset_code", 0, rd_val);
        bus_read(PI_ADDR_CTRL, rd_val);
        check_eq("reset_ctrl", 0, rd_val);
        bus_write(PI_ADDR_CODE, 5'h13);
        bus_read(PI_ADDR_CODE, rd_val);
        check_eq("rw_code", 5'h13, rd_val);
        bus_write(PI_ADDR_CTRL, 5'h1f);  // only enable is implemented
        bus_read(PI_ADDR_CTRL, rd_val);
        check_eq("rw_ctrl", 5'h01, rd_val);
        bus_write(2'd2, 5'h1f);
        bus_read(2'd2, rd_val);
        check_eq("unmapped_2", 0, rd_val);
        bus_read(2'd3, rd_val);
        check_eq("unmapped_3", 0, rd_val);
        bus_read(PI_ADDR_CODE, rd_val);
        check_eq("code_kept", 5'h13, rd_val);
        for (int c = 0; c < `PI_NPH; c++) begin
            code = pi_word_w'(c << `PI_NFINE);  // fine 0
            apply_code($sformatf("coarse_%0d", c), code);
        end
        for (int i = 0; i < 32; i++) begin
            code = pi_word_w'(i);
            apply_code($sformatf("sweep_%0d", i), code);
        end
        for (int i = 0; i < 30; i++) begin
            rnd  = $random(seed);
            code = rnd[pi_word_w-1:0];
            apply_code($sformatf("random_%0d_code_%0d", i, code), code);
        end
        bus_write(PI_ADDR_CTRL, 5'h00);
        edges0 = rise_cnt;
        #(2 * ph_period_ns);
        check_eq("disable_edges", 0, rise_cnt - edges0);
        check_eq("disable_level", 0, ph_out);
        bus_write(PI_ADDR_CTRL, 5'h01);
        measure_offset("reenable", code);  // held code comes back
        $display("Simulation finished: PASS");
        $finish;
    end

endmodule

// File: phase_interp_top.f
+incdir+src
src/pi_pkg.sv
src/pi_ctrl_if.sv
src/pi_wb_ctrl.sv
src/phase_select_mux.sv
src/phase_blender_1bit.sv
src/phase_blender_tree.sv
src/phase_interp_top.sv
sim/tb_clk_gen.sv
sim/phase_interp_assert.sv
sim/phase_interp_tb.sv
